//--- run_sim.sh
#!/bin/sh
# Build and run the UART peripheral testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=uart_periph_sim

verilator --binary -f uart_periph.f --top-module uart_periph_tb -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" "$LOG"; then
    echo "Simulation reported failures, see $LOG"
    exit 1
fi

echo "Simulation passed"
exit 0

//--- src/uart_baud_gen.sv
`timescale 1ns/100ps

module uart_baud_gen (
    input  logic                clk,
    input  logic                rst,
    input  uart_pkg::baud_div_t baud_div,
    output logic                sample_tick
);
    import uart_pkg::*;

    baud_div_t prescaler;

    // Count 0..baud_div, one tick per wrap
    always_ff @(posedge clk) begin
        if (rst) begin
            prescaler   <= '0;
            sample_tick <= 1'b0;
        end else begin
            if (prescaler == baud_div) begin
                prescaler   <= '0;
                sample_tick <= 1'b1;
            end else begin
                prescaler   <= prescaler + 1'b1;
                sample_tick <= 1'b0;
            end
        end
    end

endmodule

//--- src/uart_params.svh
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// Register map, three consecutive registers from the base
`define UART_BASE_ADDR  8'h00
`define UART_BAUD_OFS   0
`define UART_CTRL_OFS   1
`define UART_BUF_OFS    2

// Sample ticks per serial bit
`define UART_OVERSAMPLE 16

// Control reset value, tx_empty set
`define UART_CTRL_RESET 8'h02

`endif

//--- src/uart_periph.sv
`timescale 1ns/100ps

module uart_periph (
    input  logic                 clk,
    input  logic                 rst,
    input  uart_pkg::reg_addr_t  addr,
    input  uart_pkg::uart_byte_t wdata,
    input  logic                 wr_en,
    input  logic                 rd_en,
    input  logic                 rx,
    output uart_pkg::uart_byte_t rdata,
    output logic                 tx
);
    import uart_pkg::*;

    baud_div_t  baud_div;
    logic       sample_tick;
    logic       rx_valid;
    uart_byte_t rx_byte;
    logic       tx_pending;
    uart_byte_t tx_byte;
    logic       tx_taken;

    // ****************************************
    // Stages
    // ****************************************
    uart_baud_gen u_baud_gen (
        .clk         (clk),
        .rst         (rst),
        .baud_div    (baud_div),
        .sample_tick (sample_tick)
    );

    uart_rx u_rx (
        .clk         (clk),
        .rst         (rst),
        .sample_tick (sample_tick),
        .rx          (rx),
        .rx_valid    (rx_valid),
        .rx_byte     (rx_byte)
    );

    uart_tx u_tx (
        .clk         (clk),
        .rst         (rst),
        .sample_tick (sample_tick),
        .tx_pending  (tx_pending),
        .tx_byte     (tx_byte),
        .tx_taken    (tx_taken),
        .tx          (tx)
    );

    // Bus side
    uart_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .addr       (addr),
        .wdata      (wdata),
        .wr_en      (wr_en),
        .rd_en      (rd_en),
        .rx_valid   (rx_valid),
        .rx_byte    (rx_byte),
        .tx_taken   (tx_taken),
        .rdata      (rdata),
        .baud_div   (baud_div),
        .tx_pending (tx_pending),
        .tx_byte    (tx_byte)
    );

endmodule

//--- src/uart_pkg.sv
package uart_pkg;

    typedef logic [7:0] uart_byte_t;    // Bus data, buffers, shifters
    typedef logic [7:0] reg_addr_t;     // Register bus address
    typedef logic [7:0] baud_div_t;     // Tick period minus one

    // Receiver FSM
    typedef enum logic [2:0] {
        RX_IDLE,
        RX_FIRST,
        RX_DATA,
        RX_STOP,
        RX_WAIT_IDLE    // Frame error, wait for line high
    } rx_state_t;

    // Transmitter FSM
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_SHIFT,
        TX_STOP
    } tx_state_t;

endpackage

//--- src/uart_regs.sv
`timescale 1ns/100ps
`include "uart_params.svh"

module uart_regs (
    input  logic                 clk,
    input  logic                 rst,
    input  uart_pkg::reg_addr_t  addr,
    input  uart_pkg::uart_byte_t wdata,
    input  logic                 wr_en,
    input  logic                 rd_en,
    input  logic                 rx_valid,
    input  uart_pkg::uart_byte_t rx_byte,
    input  logic                 tx_taken,
    output uart_pkg::uart_byte_t rdata,
    output uart_pkg::baud_div_t  baud_div,
    output logic                 tx_pending,
    output uart_pkg::uart_byte_t tx_byte
);
    import uart_pkg::*;

    localparam reg_addr_t  baud_addr  = reg_addr_t'(`UART_BASE_ADDR + `UART_BAUD_OFS);
    localparam reg_addr_t  ctrl_addr  = reg_addr_t'(`UART_BASE_ADDR + `UART_CTRL_OFS);
    localparam reg_addr_t  buf_addr   = reg_addr_t'(`UART_BASE_ADDR + `UART_BUF_OFS);
    localparam uart_byte_t ctrl_reset = `UART_CTRL_RESET;

    logic       sel_baud;
    logic       sel_ctrl;
    logic       sel_buf;
    logic [5:0] ctrl_scratch;    // Bits 7..2, no function
    logic       rx_full;
    logic       tx_empty;
    uart_byte_t rx_buf;
    uart_byte_t rd_mux;

    assign sel_baud = (addr == baud_addr);
    assign sel_ctrl = (addr == ctrl_addr);
    assign sel_buf  = (addr == buf_addr);

    // ****************************************
    // Registers and status flags
    // ****************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            baud_div     <= '0;
            ctrl_scratch <= ctrl_reset[7:2];
            tx_empty     <= ctrl_reset[1];
            rx_full      <= ctrl_reset[0];
            rx_buf       <= '0;
            rdata        <= '0;
        end else begin
            if (wr_en && sel_baud) baud_div <= wdata;
            if (wr_en && sel_ctrl) ctrl_scratch <= wdata[7:2];    // Flags are read only
            if (rx_valid) rx_buf <= rx_byte;

            // Buffer read clears, wins over a new frame
            if (rd_en && sel_buf) begin
                rx_full <= 1'b0;
            end else if (rx_valid) begin
                rx_full <= 1'b1;
            end

            // Buffer write wins over the take
            if (wr_en && sel_buf) begin
                tx_empty <= 1'b0;
            end else if (tx_taken) begin
                tx_empty <= 1'b1;
            end

            if (rd_en) rdata <= rd_mux;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && sel_buf) tx_byte <= wdata;
    end

    // Read data select, unmapped reads 0
    always_comb begin
        if (sel_baud) begin
            rd_mux = baud_div;
        end else if (sel_ctrl) begin
            rd_mux = {ctrl_scratch, tx_empty, rx_full};
        end else if (sel_buf) begin
            rd_mux = rx_buf;
        end else begin
            rd_mux = '0;
        end
    end

    assign tx_pending = ~tx_empty;

endmodule

//--- src/uart_rx.sv
`timescale 1ns/100ps
`include "uart_params.svh"

module uart_rx (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 sample_tick,
    input  logic                 rx,
    output logic                 rx_valid,
    output uart_pkg::uart_byte_t rx_byte
);
    import uart_pkg::*;

    localparam int dly_w = $clog2(`UART_OVERSAMPLE);
    localparam logic [dly_w-1:0] dly_last = dly_w'(`UART_OVERSAMPLE - 1);
    localparam logic [dly_w-1:0] dly_half = dly_w'(`UART_OVERSAMPLE / 2 - 1);

    logic             sync_0;
    logic             sync_1;
    logic             rx_clean;
    rx_state_t        state;
    logic [dly_w-1:0] delay;
    logic [2:0]       bit_cnt;
    logic             shift_en;

    // ****************************************
    // Synchronizer clocked by the sample tick
    // ****************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            sync_0 <= 1'b1;
            sync_1 <= 1'b1;
        end else if (sample_tick) begin
            sync_0 <= rx;
            sync_1 <= sync_0;
        end
    end

    assign rx_clean = sync_0 & sync_1;    // High only when both flops are high

    // ****************************************
    // Receive FSM
    // ****************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= RX_IDLE;
            delay    <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (sample_tick) begin
                case (state)
                    RX_IDLE: begin
                        delay <= '0;
                        if (!rx_clean) state <= RX_FIRST;    // Start bit edge
                    end
                    RX_FIRST: begin
                        // Move to the middle of the start bit
                        if (delay == dly_half) begin
                            delay <= '0;
                            state <= RX_DATA;
                        end else begin
                            delay <= delay + 1'b1;
                        end
                    end
                    RX_DATA: begin
                        if (delay == dly_last) begin
                            delay   <= '0;
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == 3'd7) state <= RX_STOP;
                        end else begin
                            delay <= delay + 1'b1;
                        end
                    end
                    RX_STOP: begin
                        if (delay == dly_last) begin
                            delay <= '0;
                            if (rx_clean) begin
                                rx_valid <= 1'b1;
                                state    <= RX_IDLE;
                            end else begin
                                state <= RX_WAIT_IDLE;    // Bad stop bit drops the frame
                            end
                        end else begin
                            delay <= delay + 1'b1;
                        end
                    end
                    RX_WAIT_IDLE: begin
                        if (rx_clean) state <= RX_IDLE;
                    end
                    default: state <= RX_IDLE;
                endcase
            end
        end
    end

    // Data bits enter at the top so the LSB lands in bit 0
    assign shift_en = sample_tick && (state == RX_DATA) && (delay == dly_last);

    always_ff @(posedge clk) begin
        if (shift_en) rx_byte <= {rx_clean, rx_byte[7:1]};
    end

endmodule

//--- src/uart_tx.sv
`timescale 1ns/100ps
`include "uart_params.svh"

module uart_tx (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 sample_tick,
    input  logic                 tx_pending,
    input  uart_pkg::uart_byte_t tx_byte,
    output logic                 tx_taken,
    output logic                 tx
);
    import uart_pkg::*;

    localparam int dly_w = $clog2(`UART_OVERSAMPLE);
    localparam logic [dly_w-1:0] dly_last = dly_w'(`UART_OVERSAMPLE - 1);
    // The idle tick that follows supplies the last stop tick
    localparam logic [dly_w-1:0] dly_stop = dly_w'(`UART_OVERSAMPLE - 2);

    tx_state_t        state;
    logic [dly_w-1:0] delay;
    logic [3:0]       bit_cnt;     // 0..7 data, 8 stop
    uart_byte_t       shift_reg;
    logic             bit_end;
    logic             data_bit;

    assign tx_taken = sample_tick && (state == TX_IDLE) && tx_pending;
    assign bit_end  = sample_tick && (state == TX_SHIFT) && (delay == dly_last);
    assign data_bit = bit_end && (bit_cnt != 4'd8);

    // ****************************************
    // Transmit FSM
    // ****************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= TX_IDLE;
            delay   <= '0;
            bit_cnt <= '0;
            tx      <= 1'b1;
        end else if (sample_tick) begin
            case (state)
                TX_IDLE: begin
                    if (tx_pending) begin
                        tx      <= 1'b0;    // Start bit
                        delay   <= '0;
                        bit_cnt <= '0;
                        state   <= TX_SHIFT;
                    end
                end
                TX_SHIFT: begin
                    if (delay == dly_last) begin
                        delay <= '0;
                        if (bit_cnt == 4'd8) begin
                            tx    <= 1'b1;    // Stop bit
                            state <= TX_STOP;
                        end else begin
                            tx      <= shift_reg[0];
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else begin
                        delay <= delay + 1'b1;
                    end
                end
                TX_STOP: begin
                    if (delay == dly_stop) begin
                        delay <= '0;
                        state <= TX_IDLE;
                    end else begin
                        delay <= delay + 1'b1;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Load on take, LSB first out
    always_ff @(posedge clk) begin
        if (tx_taken) begin
            shift_reg <= tx_byte;
        end else if (data_bit) begin
            shift_reg <= {1'b0, shift_reg[7:1]};
        end
    end

endmodule

//--- test/uart_periph_golden.txt
# Columns: command word, then hex operands
# WR addr data | RD addr expect | RXSEND byte stop | TXEXPECT byte | POLL addr mask value | END
# Reset values, read back, unmapped reads
RD 01 02
RD 02 00
RD 00 00
WR 00 5A
RD 00 5A
WR 00 00
WR 01 FF
RD 01 FE
WR 01 A9
RD 01 AA
WR 01 00
RD 01 02
RD 03 00
RD 80 00
END
# Transmit at divisor 0, then divisor 3
WR 02 A5
RD 01 00
TXEXPECT A5
POLL 01 02 02
WR 00 03
WR 02 96
RD 01 00
TXEXPECT 96
POLL 01 02 02
END
# Receive one good frame
RXSEND 3C 1
POLL 01 01 01
RD 02 3C
RD 01 02
END
# Low stop bit drops the frame
RXSEND 5A 0
RD 01 02
RXSEND C3 1
POLL 01 01 01
RD 02 C3
RD 01 02
END
# Second write while the first frame is in flight
WR 02 11
POLL 01 02 02
WR 02 22
TXEXPECT 11
TXEXPECT 22
POLL 01 02 02
END

//--- test/uart_periph_tb.sv
`timescale 1ns/100ps
`include "uart_params.svh"

module uart_periph_tb;
    import uart_pkg::*;

    localparam int clk_half  = 4;                 // 8 ns period
    localparam int run_limit = 10 * 160 * 256;    // Ten frames at the slowest divisor
    localparam int div_slack = 256;               // Prescaler wrap after a divisor change
    localparam reg_addr_t baud_addr = reg_addr_t'(`UART_BASE_ADDR + `UART_BAUD_OFS);

    logic       clk = 1'b0;
    logic       rst;
    reg_addr_t  addr;
    uart_byte_t wdata;
    logic       wr_en;
    logic       rd_en;
    logic       rx;
    uart_byte_t rdata;
    logic       tx;

    int        cycle_count = 0;
    int        fall_cycle  = 0;
    logic      tx_prev     = 1'b1;
    baud_div_t baud_val    = '0;    // Last value written to the divisor
    int        error_count = 0;
    int        test_count  = 0;

    uart_periph u_uart_periph (
        .clk   (clk),
        .rst   (rst),
        .addr  (addr),
        .wdata (wdata),
        .wr_en (wr_en),
        .rd_en (rd_en),
        .rx    (rx),
        .rdata (rdata),
        .tx    (tx)
    );

    always #(clk_half) clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= run_limit) begin
            $display("Run stopped after the cycle limit of %0d clocks", run_limit);
            $display("Errors found");
            $finish;
        end
    end

    // Cycle of the latest high to low step on tx
    always @(negedge clk) begin
        tx_prev <= tx;
        if (tx_prev && !tx) fall_cycle <= cycle_count;
    end

    // ****************************************
    // Helpers
    // ****************************************
    function automatic int bit_clocks();
        return `UART_OVERSAMPLE * (int'(baud_val) + 1);
    endfunction

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s expected %02h, got %02h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic wait_for_cycle(input int target);
        while (cycle_count < target) @(negedge clk);
    endtask

    task automatic bus_write(input reg_addr_t a, input uart_byte_t d);
        addr  = a;
        wdata = d;
        wr_en = 1'b1;
        @(negedge clk);
        wr_en = 1'b0;
        if (a == baud_addr) baud_val = d;
    endtask

    task automatic bus_read(input reg_addr_t a, output uart_byte_t d);
        addr  = a;
        rd_en = 1'b1;
        @(negedge clk);
        rd_en = 1'b0;
        d     = rdata;    // Registered on the edge just passed
    endtask

    task automatic poll_flag(input reg_addr_t a, input uart_byte_t mask, input uart_byte_t value);
        int         tries;
        logic       hit;
        uart_byte_t data;
        tries = 0;
        hit   = 1'b0;
        while (!hit && tries < 12 * bit_clocks() + div_slack) begin
            bus_read(a, data);
            hit = ((data & mask) === value);
            tries++;
        end
        if (!hit) begin
            $display("POLL at %0t: bits %02h at address %02h never reached %02h",
                     $time, mask, a, value);
            error_count++;
        end
    endtask

    // Drive one 8N1 frame on rx followed by one idle bit
    task automatic send_rx_frame(input uart_byte_t data, input logic stop_bit);
        logic [9:0] frame;
        int         bt;
        bt    = bit_clocks();
        frame = {stop_bit, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rx = frame[i];
            repeat (bt) @(negedge clk);
        end
        rx = 1'b1;
        repeat (bt) @(negedge clk);
    endtask

    // Sample tx at the middle of each bit as counted from the start bit edge
    task automatic expect_tx_frame(input uart_byte_t expected);
        int         bt;
        int         waited;
        int         target;
        uart_byte_t got;
        bt     = bit_clocks();
        waited = 0;
        got    = '0;
        while (tx !== 1'b0 && waited < 12 * bt + div_slack) begin
            @(negedge clk);
            waited++;
        end
        if (tx !== 1'b0) begin
            $display("TXEXPECT at %0t: no start bit appeared on tx", $time);
            error_count++;
        end else begin
            @(negedge clk);    // Let fall_cycle settle
            target = fall_cycle + bt / 2;
            if (cycle_count > target) begin
                $display("TXEXPECT at %0t: start bit began too early to sample", $time);
                error_count++;
            end else begin
                wait_for_cycle(target);
                check_value("tx start bit", 8'h00, {7'b0, tx});
                for (int i = 0; i < 8; i++) begin
                    target += bt;
                    wait_for_cycle(target);
                    got[i] = tx;
                end
                check_value("tx byte", expected, got);
                target += bt;
                wait_for_cycle(target);
                check_value("tx stop bit", 8'h01, {7'b0, tx});
            end
        end
    endtask

    // ****************************************
    // Golden file interpreter
    // ****************************************
    task automatic run_golden(input int fd);
        string         cmd;
        logic [1023:0] line;
        int            code;
        int            test_start;
        logic          done;
        uart_byte_t    a;
        uart_byte_t    b;
        uart_byte_t    c;
        uart_byte_t    data;
        done       = 1'b0;
        test_start = 0;
        while (!done) begin
            code = $fscanf(fd, "%s", cmd);
            if (code != 1) begin
                done = 1'b1;    // End of file
            end else if (cmd == "#") begin
                code = $fgets(line, fd);
            end else if (cmd == "WR" || cmd == "RD" || cmd == "RXSEND") begin
                code = $fscanf(fd, "%h %h", a, b);
                if (code != 2) begin
                    $display("Golden file line %s is missing its operands", cmd);
                    error_count++;
                    done = 1'b1;
                end else if (cmd == "WR") begin
                    bus_write(a, b);
                end else if (cmd == "RD") begin
                    bus_read(a, data);
                    check_value("rdata", b, data);
                end else begin
                    send_rx_frame(a, b[0]);
                end
            end else if (cmd == "TXEXPECT") begin
                code = $fscanf(fd, "%h", a);
                expect_tx_frame(a);
            end else if (cmd == "POLL") begin
                code = $fscanf(fd, "%h %h %h", a, b, c);
                poll_flag(a, b, c);
            end else if (cmd == "END") begin
                test_count++;
                if (error_count == test_start) begin
                    $display("test %0d: PASS", test_count);
                end else begin
                    $display("test %0d: FAIL, %0d failures", test_count,
                             error_count - test_start);
                end
                test_start = error_count;
            end else begin
                $display("Golden file holds an unknown command %s", cmd);
                error_count++;
                done = 1'b1;
            end
        end
    endtask

    initial begin
        int fd;
        $timeformat(-9, 1, " ns", 0);
        rst   = 1'b1;
        addr  = '0;
        wdata = '0;
        wr_en = 1'b0;
        rd_en = 1'b0;
        rx    = 1'b1;    // Idle line
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        fd = $fopen("test/uart_periph_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open test/uart_periph_golden.txt");
            error_count++;
        end else begin
            run_golden(fd);
            $fclose(fd);
        end

        $display("Tests run: %0d, failures: %0d", test_count, error_count);
        if (error_count == 0 && test_count > 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- uart_periph.f
+incdir+src
src/uart_pkg.sv
src/uart_baud_gen.sv
src/uart_rx.sv
src/uart_tx.sv
src/uart_regs.sv
src/uart_periph.sv
test/uart_periph_tb.sv
